/* Makefile */
VERILATOR ?= verilator
TOP := hub75_panel_tb
RTL_TOP := hub75_panel
FILE_LIST := hub75_panel.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing --assert -Wno-fatal
PASS_TEXT := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

/* bench/hub75_panel_tb.sv */
module hub75_panel_tb;

    // small panel keeps the run short
    localparam int width = 8;
    localparam int half_height = 4;
    localparam int unit = 2;
    localparam int overlap = 3;
    localparam int planes = hub75_pkg::color_depth;
    // two passes over every row
    localparam int latch_target = 2 * planes * half_height;
    localparam int latch_timeout = 400;

    logic clk_in;
    logic reset;
    logic wr_en;
    hub75_pkg::line_t wr_line;
    hub75_pkg::column_t wr_column;
    hub75_pkg::pixel_t wr_pixel;
    hub75_pkg::hub75_pins_t pins;

    // model copy of the frame keyed by half, row and column
    hub75_pkg::pixel_t model_frame [int];

    integer seed;
    int latch_count;
    int strobe_count;
    int oe_length;
    int colour_checks;
    int oe_checks;
    logic frame_ready;
    logic colour_on;
    logic monitor_on;

    tb_clock #(.period(20)) tb_clock_inst (.clk_in(clk_in));

    hub75_panel #(
        .panel_width       (width),
        .panel_half_height (half_height),
        .oe_unit           (unit),
        .scan_overlap      (overlap)
    ) hub75_panel_inst (
        .clk_in    (clk_in),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_line   (wr_line),
        .wr_column (wr_column),
        .wr_pixel  (wr_pixel),
        .pins      (pins)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(string test_name, int expected, int actual);
        abort_run($sformatf("Error %s: expected %0d, actual %0d", test_name, expected, actual));
    endtask

    // strobes must all be quiet
    task automatic check_idle_pins(string test_name);
        assert ({pins.pixel_clock, pins.row_latch, pins.output_enable} == 3'b000)
        else report_mismatch(test_name, 0,
            int'({pins.pixel_clock, pins.row_latch, pins.output_enable}));
    endtask

    // bounded wait for the next latch on the pins
    task automatic wait_next_latch();
        int start_count;
        int cycles;
        start_count = latch_count;
        cycles = 0;
        while (latch_count == start_count && cycles < latch_timeout) begin
            @(posedge clk_in);
            cycles++;
        end
        if (latch_count == start_count) begin
            abort_run("no row latch seen on the pins within the timeout");
        end
    endtask

    function automatic int frame_key(int half, int row, int column);
        return (half * half_height + row) * width + column;
    endfunction

    // shift k carries planes from 5 down to 0
    function automatic int plane_of(int k);
        return planes - 1 - (k % planes);
    endfunction

    // row steps once per six shifts and wraps
    function automatic int row_of(int k);
        return (k / planes) % half_height;
    endfunction

    function automatic logic [2:0] plane_bits(hub75_pkg::pixel_t p, int plane);
        hub75_pkg::channel_t r;
        hub75_pkg::channel_t g;
        hub75_pkg::channel_t b;
        r = p.red >> plane;
        g = p.green >> plane;
        b = p.blue >> plane;
        return {r[0], g[0], b[0]};
    endfunction

    // pins sampled on the falling edge halfway between updates
    always @(negedge clk_in) begin : pin_monitor
        int column;
        int expected_oe;
        logic [5:0] expected_colour;
        logic [5:0] actual_colour;
        if (monitor_on) begin
            if (pins.pixel_clock) begin
                if (colour_on && strobe_count < width) begin
                    // columns leave highest first
                    column = width - 1 - strobe_count;
                    expected_colour = {
                        plane_bits(model_frame[frame_key(0, row_of(latch_count), column)],
                            plane_of(latch_count)),
                        plane_bits(model_frame[frame_key(1, row_of(latch_count), column)],
                            plane_of(latch_count))};
                    actual_colour = {pins.r0, pins.g0, pins.b0, pins.r1, pins.g1, pins.b1};
                    assert (actual_colour == expected_colour)
                    else report_mismatch("colour bits", int'(expected_colour),
                        int'(actual_colour));
                    colour_checks++;
                end
                strobe_count++;
            end
            if (pins.row_latch) begin
                assert (strobe_count == width)
                else report_mismatch("pixel clocks per latch", width, strobe_count);
                latch_count++;
                strobe_count = 0;
                // next shift reads only a complete frame
                colour_on = frame_ready;
            end
            if (pins.output_enable) begin
                oe_length++;
                assert (pins.row_address == hub75_pkg::row_t'(row_of(latch_count - 1)))
                else report_mismatch("row address", row_of(latch_count - 1),
                    int'(pins.row_address));
            end else if (oe_length != 0) begin
                // lit time follows the plane of the latch before
                if (latch_count == 1) begin
                    expected_oe = 1;
                end else begin
                    expected_oe = unit << plane_of(latch_count - 2);
                end
                assert (oe_length == expected_oe)
                else report_mismatch("output enable length", expected_oe, oe_length);
                oe_checks++;
                oe_length = 0;
            end
        end
    end

    initial begin
        logic [31:0] random_word;
        hub75_pkg::pixel_t pixel;
        seed = 19;
        latch_count = 0;
        strobe_count = 0;
        oe_length = 0;
        colour_checks = 0;
        oe_checks = 0;
        frame_ready = 1'b0;
        colour_on = 1'b0;
        monitor_on = 1'b0;
        reset = 1'b1;
        wr_en = 1'b0;
        wr_line = '0;
        wr_column = '0;
        wr_pixel = '0;

        // five cycles of reset with the strobes low throughout
        for (int i = 0; i < 5; i++) begin
            @(negedge clk_in);
            check_idle_pins("strobes in reset");
        end
        reset = 1'b0;
        @(negedge clk_in);
        check_idle_pins("strobes after reset");
        monitor_on = 1'b1;

        // random frame with one write per cycle
        for (int half = 0; half < 2; half++) begin
            for (int row = 0; row < half_height; row++) begin
                for (int col = 0; col < width; col++) begin
                    random_word = $random(seed);
                    pixel = random_word[$bits(hub75_pkg::pixel_t)-1:0];
                    model_frame[frame_key(half, row, col)] = pixel;
                    wr_en = 1'b1;
                    wr_line = hub75_pkg::line_t'(half * hub75_pkg::max_half_height + row);
                    wr_column = hub75_pkg::column_t'(col);
                    wr_pixel = pixel;
                    @(negedge clk_in);
                end
            end
        end
        wr_en = 1'b0;
        frame_ready = 1'b1;

        while (latch_count < latch_target) begin
            wait_next_latch();
        end

        assert (colour_checks > 0)
        else abort_run("no pixel clock was checked against the frame");
        assert (oe_checks >= latch_target - 2)
        else report_mismatch("output enable pulses", latch_target - 2, oe_checks);

        $display("Test passed");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock #(
    parameter int period = 20
) (
    output logic clk_in
);

    // starts low, first rising edge at half a period
    initial begin
        clk_in = 1'b0;
    end

    // free running square wave
    always begin
        #(period / 2);
        clk_in = ~clk_in;
    end

endmodule

/* common/hub75_pkg.sv */
package hub75_pkg;

    // largest supported panel geometry
    localparam int max_width = 64;
    localparam int max_half_height = 16;

    // bits per colour, also the number of brightness planes
    localparam int color_depth = 6;

    // column address within a row
    typedef logic [$clog2(max_width)-1:0] column_t;

    // row address within one half
    typedef logic [$clog2(max_half_height)-1:0] row_t;

    // full panel row, top bit picks the lower half
    typedef logic [$clog2(max_half_height):0] line_t;

    // one colour intensity
    typedef logic [color_depth-1:0] channel_t;

    // one-hot plane select, msb plane goes first
    typedef logic [color_depth-1:0] mask_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } pixel_t;

    // same column and row in both halves
    typedef struct packed {
        pixel_t upper;
        pixel_t lower;
    } pixel_pair_t;

    // output_enable high means lit, polarity fixed up off-chip
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
        logic pixel_clock;
        logic row_latch;
        logic output_enable;
        row_t row_address;
    } hub75_pins_t;

endpackage

/* hub75_panel.f */
common/hub75_pkg.sv
matrix_scan/scan_timer.sv
matrix_scan/matrix_scan.sv
source/frame_buffer.sv
source/bit_plane_select.sv
source/hub75_panel.sv
bench/tb_clock.sv
bench/hub75_panel_tb.sv

/* matrix_scan/matrix_scan.sv */
module matrix_scan #(
    parameter int panel_width = 64,
    parameter int panel_half_height = 16,
    parameter int oe_unit = 23,
    parameter int scan_overlap = 67
) (
    input  logic               clk_in,
    input  logic               reset,
    // row being shifted out now
    output hub75_pkg::column_t column_address,
    output hub75_pkg::row_t    row_address,
    // row currently lit
    output hub75_pkg::row_t    row_address_active,
    output logic               pixel_strobe,
    output logic               row_latch,
    output logic               output_enable,
    // plane being shifted out now
    output hub75_pkg::mask_t   brightness_mask
);

    // longest lit time of plane 5 sizes the oe counter
    localparam int oe_max = oe_unit << (hub75_pkg::color_depth - 1);
    localparam int oe_width = $clog2(oe_max + 1);

    typedef logic [$clog2(hub75_pkg::max_width):0] load_count_t;
    typedef logic [oe_width-1:0] oe_count_t;

    localparam hub75_pkg::mask_t top_plane =
        hub75_pkg::mask_t'(1) << (hub75_pkg::color_depth - 1);

    logic [1:0] advance_sr;
    logic [1:0] latch_sr;
    logic advance_req;
    logic load_start;
    logic pixel_load_en;
    logic scan_busy;
    hub75_pkg::mask_t mask_active;
    oe_count_t oe_weight;
    oe_count_t oe_counter;

    // shift, latch and the cycle after are one busy window
    assign scan_busy = pixel_load_en | (|latch_sr);

    // next shift may begin once the lit time runs low
    assign advance_req = ~scan_busy &
        (~output_enable | (oe_counter < oe_count_t'(scan_overlap)));

    // rising edge of the request kicks a load phase
    assign load_start = advance_sr[0] & ~advance_sr[1];

    // latch two cycles after the load enable drops
    assign row_latch = (latch_sr == 2'b10);

    // panel_width load cycles
    scan_timer #(
        .counter_width($bits(load_count_t))
    ) load_timer (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (load_start),
        .value   (load_count_t'(panel_width)),
        .counter (),
        .running (pixel_load_en)
    );

    // column walks down from panel_width-1 alongside the load
    scan_timer #(
        .counter_width($bits(hub75_pkg::column_t))
    ) column_timer (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (load_start),
        .value   (hub75_pkg::column_t'(panel_width - 1)),
        .counter (column_address),
        .running ()
    );

    // weight of the plane that was active when the latch fired
    always_comb begin
        oe_weight = oe_count_t'(1);
        for (int i = 0; i < hub75_pkg::color_depth; i++) begin
            if (mask_active[i]) begin
                oe_weight = oe_count_t'(oe_unit << i);
            end
        end
    end

    // lit period starts the cycle after row_latch
    scan_timer #(
        .counter_width(oe_width)
    ) oe_timer (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (row_latch),
        .value   (oe_weight),
        .counter (oe_counter),
        .running (output_enable)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            advance_sr <= 2'b00;
            latch_sr <= 2'b00;
            pixel_strobe <= 1'b0;
            brightness_mask <= top_plane;
            mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            advance_sr <= {advance_sr[0], advance_req};
            latch_sr <= {latch_sr[0], pixel_load_en};
            // pixel data trails the address by one cycle
            pixel_strobe <= pixel_load_en;
            if (row_latch) begin
                mask_active <= brightness_mask;
                row_address_active <= row_address;
                if (brightness_mask[0]) begin
                    // after the last plane move on to the next row
                    brightness_mask <= top_plane;
                    if (row_address == hub75_pkg::row_t'(panel_half_height - 1)) begin
                        row_address <= '0;
                    end else begin
                        row_address <= row_address + hub75_pkg::row_t'(1);
                    end
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

endmodule

/* matrix_scan/scan_timer.sv */
module scan_timer #(
    parameter int counter_width = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    // level, held high keeps the counter parked at value
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] counter,
    output logic                     running
);

    typedef logic [counter_width-1:0] count_t;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            // one step per clock, stops at zero
            counter <= counter - count_t'(1);
        end
    end

    // busy for as long as there is count left
    assign running = (counter != '0);

endmodule

/* source/bit_plane_select.sv */
module bit_plane_select (
    input  logic                   clk_in,
    input  logic                   reset,
    // read data, one cycle behind the scan address
    input  hub75_pkg::pixel_pair_t pixel_pair,
    input  hub75_pkg::mask_t       brightness_mask,
    input  logic                   pixel_strobe,
    input  logic                   row_latch,
    input  logic                   output_enable,
    input  hub75_pkg::row_t        row_address_active,
    output hub75_pkg::hub75_pins_t pins
);

    // mask delayed to meet the buffer read latency
    hub75_pkg::mask_t mask_d;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            mask_d <= '0;
        end else begin
            mask_d <= brightness_mask;
        end
    end

    // single pin stage, colour travels with its own pixel clock
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pins <= '0;
        end else begin
            // upper half
            pins.r0 <= |(pixel_pair.upper.red & mask_d);
            pins.g0 <= |(pixel_pair.upper.green & mask_d);
            pins.b0 <= |(pixel_pair.upper.blue & mask_d);
            // lower half
            pins.r1 <= |(pixel_pair.lower.red & mask_d);
            pins.g1 <= |(pixel_pair.lower.green & mask_d);
            pins.b1 <= |(pixel_pair.lower.blue & mask_d);
            pins.pixel_clock <= pixel_strobe;
            pins.row_latch <= row_latch;
            pins.output_enable <= output_enable;
            // lit row, not the one being shifted
            pins.row_address <= row_address_active;
        end
    end

endmodule

/* source/frame_buffer.sv */
module frame_buffer (
    input  logic                   clk_in,
    // writer side, one pixel per strobe
    input  logic                   wr_en,
    input  hub75_pkg::line_t       wr_line,
    input  hub75_pkg::column_t     wr_column,
    input  hub75_pkg::pixel_t      wr_pixel,
    // scan side
    input  hub75_pkg::column_t     column_address,
    input  hub75_pkg::row_t        row_address,
    output hub75_pkg::pixel_pair_t pixel_pair
);

    // sized for the largest panel, smaller ones use a corner of it
    localparam int depth = hub75_pkg::max_width * hub75_pkg::max_half_height;

    typedef logic [$clog2(depth)-1:0] addr_t;

    hub75_pkg::pixel_t upper_mem [depth];
    hub75_pkg::pixel_t lower_mem [depth];

    addr_t wr_addr;
    addr_t rd_addr;
    logic wr_lower;

    // row within the half sits above the column
    assign wr_addr = {wr_line[$bits(hub75_pkg::row_t)-1:0], wr_column};
    assign wr_lower = wr_line[$bits(hub75_pkg::line_t)-1];
    assign rd_addr = {row_address, column_address};

    // upper half, lines 0 to 15
    always_ff @(posedge clk_in) begin
        if (wr_en && !wr_lower) begin
            upper_mem[wr_addr] <= wr_pixel;
        end
        pixel_pair.upper <= upper_mem[rd_addr];
    end

    // lower half, lines 16 to 31
    always_ff @(posedge clk_in) begin
        if (wr_en && wr_lower) begin
            lower_mem[wr_addr] <= wr_pixel;
        end
        pixel_pair.lower <= lower_mem[rd_addr];
    end

endmodule

/* source/hub75_panel.sv */
module hub75_panel #(
    parameter int panel_width = 64,
    parameter int panel_half_height = 16,
    // plane 0 lit cycles
    parameter int oe_unit = 23,
    // lit cycles left when the next shift may start
    parameter int scan_overlap = 67
) (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   wr_en,
    input  hub75_pkg::line_t       wr_line,
    input  hub75_pkg::column_t     wr_column,
    input  hub75_pkg::pixel_t      wr_pixel,
    output hub75_pkg::hub75_pins_t pins
);

    hub75_pkg::column_t column_address;
    hub75_pkg::row_t row_address;
    hub75_pkg::row_t row_address_active;
    logic pixel_strobe;
    logic row_latch;
    logic output_enable;
    hub75_pkg::mask_t brightness_mask;
    hub75_pkg::pixel_pair_t pixel_pair;

    // timing and addresses
    matrix_scan #(
        .panel_width       (panel_width),
        .panel_half_height (panel_half_height),
        .oe_unit           (oe_unit),
        .scan_overlap      (scan_overlap)
    ) matrix_scan_inst (
        .clk_in             (clk_in),
        .reset              (reset),
        .column_address     (column_address),
        .row_address        (row_address),
        .row_address_active (row_address_active),
        .pixel_strobe       (pixel_strobe),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .brightness_mask    (brightness_mask)
    );

    // pixel store, both halves read together
    frame_buffer frame_buffer_inst (
        .clk_in         (clk_in),
        .wr_en          (wr_en),
        .wr_line        (wr_line),
        .wr_column      (wr_column),
        .wr_pixel       (wr_pixel),
        .column_address (column_address),
        .row_address    (row_address),
        .pixel_pair     (pixel_pair)
    );

    // plane bit pick and pin register
    bit_plane_select bit_plane_select_inst (
        .clk_in             (clk_in),
        .reset              (reset),
        .pixel_pair         (pixel_pair),
        .brightness_mask    (brightness_mask),
        .pixel_strobe       (pixel_strobe),
        .row_latch          (row_latch),
        .output_enable      (output_enable),
        .row_address_active (row_address_active),
        .pins               (pins)
    );

endmodule
